// ==== rtl/lsu_pkg.sv ====
// --------------------------------------
// Shared sizes, encodings and bundles of the LSU
// Addresses and data are 32 bits wide, no virtual memory
// Buffer depth must be a power of two
// --------------------------------------

package lsu_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned TRANS_ID_W = 3;
  localparam int unsigned BUF_DEPTH  = 2;
  localparam int unsigned BUF_PTR_W  = $clog2(BUF_DEPTH);
  localparam int unsigned BUF_CNT_W  = $clog2(BUF_DEPTH + 1);

  // APB register offsets
  localparam logic [XLEN-1:0] REG_BASE_ADDR    = 32'h0;
  localparam logic [XLEN-1:0] REG_LIMIT_ADDR   = 32'h4;
  localparam logic [XLEN-1:0] REG_EXC_CNT_ADDR = 32'h8;

  // Window after reset covers the whole address space
  localparam logic [XLEN-1:0] REGION_BASE_RST  = '0;
  localparam logic [XLEN-1:0] REGION_LIMIT_RST = '1;

  typedef enum logic [2:0] {LB, LBU, LH, LHU, LW, SB, SH, SW} lsu_op_e;

  typedef enum logic {FU_LOAD, FU_STORE} fu_e;

  typedef enum logic [3:0] {
    CAUSE_LD_MISALIGNED = 4'd4,
    CAUSE_LD_ACCESS     = 4'd5,
    CAUSE_ST_MISALIGNED = 4'd6,
    CAUSE_ST_ACCESS     = 4'd7
  } exc_cause_e;

  // --------------------------------------
  // Bundles
  // --------------------------------------
  typedef struct packed {
    fu_e                   fu;
    lsu_op_e               op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       imm;
    logic [TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  typedef struct packed {
    fu_e                   fu;
    lsu_op_e               op;
    logic [XLEN-1:0]       vaddr;
    logic [XLEN-1:0]       wdata;
    logic [3:0]            be;
    logic [TRANS_ID_W-1:0] trans_id;
    exception_t            ex;
  } lsu_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] limit;
  } region_t;

  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       result;
    exception_t            ex;
  } load_result_t;

  typedef struct packed {
    logic                  valid;
    logic [TRANS_ID_W-1:0] trans_id;
    exception_t            ex;
  } store_result_t;

  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
    logic [3:0]      be;
  } ld_req_t;

  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
    logic [3:0]      be;
    logic [XLEN-1:0] wdata;
  } st_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } ld_rsp_t;

  typedef struct packed {
    logic gnt;
  } st_rsp_t;

  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [XLEN-1:0] paddr;
    logic [XLEN-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic            pready;
    logic [XLEN-1:0] prdata;
    logic            pslverr;
  } apb_rsp_t;

endpackage

// ==== rtl/lsu_agu.sv ====
// --------------------------------------
// Address generation and exception check
// Purely combinational, one request per issue
// Region check looks at the first byte only
// --------------------------------------
`timescale 1ns/10ps

module lsu_agu
  import lsu_pkg::*;
(
  input  fu_data_t  fu_data_i,
  input  region_t   region_i,
  output lsu_ctrl_t req_o
);

  logic [XLEN-1:0] vaddr;
  logic [1:0]      size;
  logic [3:0]      be;
  logic            misaligned;
  logic            out_of_region;

  // Two's complement add covers the signed immediate
  assign vaddr = fu_data_i.operand_a + fu_data_i.imm;

  // Access size: 0 byte, 1 half-word, 2 word
  always_comb begin
    unique case (fu_data_i.op)
      LB, LBU, SB: size = 2'd0;
      LH, LHU, SH: size = 2'd1;
      default:     size = 2'd2;
    endcase
  end

  always_comb begin
    unique case (size)
      2'd0:    be = 4'b0001 << vaddr[1:0];
      2'd1:    be = 4'b0011 << vaddr[1:0];
      default: be = 4'b1111;
    endcase
  end

  always_comb begin
    unique case (size)
      2'd1:    misaligned = vaddr[0];
      2'd2:    misaligned = |vaddr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  assign out_of_region = (vaddr < region_i.base) || (vaddr > region_i.limit);

  // --------------------------------------
  // Request assembly
  // --------------------------------------
  always_comb begin
    req_o.fu       = fu_data_i.fu;
    req_o.op       = fu_data_i.op;
    req_o.vaddr    = vaddr;
    req_o.wdata    = fu_data_i.operand_b << {vaddr[1:0], 3'b000};
    req_o.be       = be;
    req_o.trans_id = fu_data_i.trans_id;

    req_o.ex.valid = misaligned || out_of_region;
    req_o.ex.tval  = req_o.ex.valid ? vaddr : '0;
    // Access fault takes priority over misalignment
    if (fu_data_i.fu == FU_LOAD) begin
      req_o.ex.cause = out_of_region ? CAUSE_LD_ACCESS : CAUSE_LD_MISALIGNED;
    end else begin
      req_o.ex.cause = out_of_region ? CAUSE_ST_ACCESS : CAUSE_ST_MISALIGNED;
    end
  end

endmodule

// ==== rtl/lsu_req_buffer.sv ====
// --------------------------------------
// In-order request buffer
// Head goes out only while both units are idle
// Caller must not push while ready_o is low
// --------------------------------------
`timescale 1ns/10ps

module lsu_req_buffer
  import lsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  lsu_ctrl_t req_i,
  output logic      ready_o,
  output lsu_ctrl_t head_o,
  output logic      ld_valid_o,
  output logic      st_valid_o,
  input  logic      ld_pop_i,
  input  logic      st_pop_i,
  input  logic      ld_busy_i,
  input  logic      st_busy_i
);

  lsu_ctrl_t              mem_q [BUF_DEPTH];
  logic [BUF_PTR_W-1:0]   rd_ptr_q;
  logic [BUF_PTR_W-1:0]   wr_ptr_q;
  logic [BUF_CNT_W-1:0]   count_q;
  logic                   pop;
  logic                   empty;
  logic                   dispatch_ok;

  assign pop     = ld_pop_i | st_pop_i;
  assign empty   = (count_q == '0);
  assign ready_o = (count_q != BUF_CNT_W'(BUF_DEPTH));
  assign head_o  = mem_q[rd_ptr_q];

  // One operation in flight past the buffer
  assign dispatch_ok = !empty && !ld_busy_i && !st_busy_i;
  assign ld_valid_o  = dispatch_ok && (head_o.fu == FU_LOAD);
  assign st_valid_o  = dispatch_ok && (head_o.fu == FU_STORE);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Issue gating lives in the top level
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> ready_o);

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop |-> !empty);

endmodule

// ==== rtl/lsu_load_unit.sv ====
// --------------------------------------
// Load unit, one load at a time
// rvalid must arrive at least one cycle after gnt
// Excepted loads return without a memory read
// --------------------------------------
`timescale 1ns/10ps

module lsu_load_unit
  import lsu_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         valid_i,
  input  lsu_ctrl_t    req_i,
  output logic         pop_o,
  output logic         busy_o,
  output ld_req_t      ld_req_o,
  input  ld_rsp_t      ld_rsp_i,
  output load_result_t load_o
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT, DONE} state_e;

  state_e          state_q;
  state_e          state_d;
  lsu_ctrl_t       ctrl_q;
  logic [XLEN-1:0] result_q;
  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] extended;

  assign pop_o  = (state_q == IDLE) && valid_i;
  assign busy_o = (state_q != IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (valid_i) begin
          state_d = req_i.ex.valid ? DONE : REQ;
        end
      end
      REQ:     if (ld_rsp_i.gnt) state_d = WAIT;
      WAIT:    if (ld_rsp_i.rvalid) state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------
  // Data alignment and extension
  // --------------------------------------
  // Accessed lane moves down to bit 0
  assign shifted = ld_rsp_i.rdata >> {ctrl_q.vaddr[1:0], 3'b000};

  always_comb begin
    unique case (ctrl_q.op)
      LB:      extended = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      LBU:     extended = {{(XLEN-8){1'b0}}, shifted[7:0]};
      LH:      extended = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      LHU:     extended = {{(XLEN-16){1'b0}}, shifted[15:0]};
      default: extended = shifted;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      ctrl_q   <= req_i;
      result_q <= '0;
    end else if ((state_q == WAIT) && ld_rsp_i.rvalid) begin
      result_q <= extended;
    end
  end

  assign ld_req_o.req  = (state_q == REQ);
  assign ld_req_o.addr = {ctrl_q.vaddr[XLEN-1:2], 2'b00};
  assign ld_req_o.be   = ctrl_q.be;

  assign load_o.valid    = (state_q == DONE);
  assign load_o.trans_id = ctrl_q.trans_id;
  assign load_o.result   = result_q;
  assign load_o.ex       = ctrl_q.ex;

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_req_o.req && !ld_rsp_i.gnt |=> ld_req_o.req && $stable(ld_req_o));

endmodule

// ==== rtl/lsu_store_unit.sv ====
// --------------------------------------
// Store unit, writes as soon as it holds a store
// Excepted stores report without a memory write
// --------------------------------------
`timescale 1ns/10ps

module lsu_store_unit
  import lsu_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          valid_i,
  input  lsu_ctrl_t     req_i,
  output logic          pop_o,
  output logic          busy_o,
  output st_req_t       st_req_o,
  input  st_rsp_t       st_rsp_i,
  output store_result_t store_o
);

  typedef enum logic [1:0] {IDLE, REQ, DONE} state_e;

  state_e    state_q;
  state_e    state_d;
  lsu_ctrl_t ctrl_q;

  assign pop_o  = (state_q == IDLE) && valid_i;
  assign busy_o = (state_q != IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (valid_i) state_d = req_i.ex.valid ? DONE : REQ;
      REQ:     if (st_rsp_i.gnt) state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      ctrl_q <= req_i;
    end
  end

  assign st_req_o.req   = (state_q == REQ);
  assign st_req_o.addr  = {ctrl_q.vaddr[XLEN-1:2], 2'b00};
  assign st_req_o.be    = ctrl_q.be;
  assign st_req_o.wdata = ctrl_q.wdata;

  assign store_o.valid    = (state_q == DONE);
  assign store_o.trans_id = ctrl_q.trans_id;
  assign store_o.ex       = ctrl_q.ex;

  // Exception flag comes from the AGU through the buffer
  a_no_write_on_ex : assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_req_o.req |-> !ctrl_q.ex.valid);

endmodule

// ==== rtl/lsu_cfg_regs.sv ====
// --------------------------------------
// APB registers: region window and exception count
// No wait states, full address compare
// Counter saturates and is read-only
// --------------------------------------
`timescale 1ns/10ps

module lsu_cfg_regs
  import lsu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_i,
  output apb_rsp_t apb_o,
  output region_t  region_o,
  input  logic     ld_exc_i,
  input  logic     st_exc_i
);

  region_t         region_q;
  logic [XLEN-1:0] exc_cnt_q;
  logic [XLEN:0]   cnt_sum;
  logic            access;
  logic            wr_en;
  logic            mapped;
  logic [XLEN-1:0] rdata;

  assign access = apb_i.psel && apb_i.penable;
  assign wr_en  = access && apb_i.pwrite;

  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (apb_i.paddr)
      REG_BASE_ADDR:    rdata = region_q.base;
      REG_LIMIT_ADDR:   rdata = region_q.limit;
      REG_EXC_CNT_ADDR: rdata = exc_cnt_q;
      default:          mapped = 1'b0;
    endcase
  end

  assign apb_o.pready  = access;
  assign apb_o.prdata  = rdata;
  assign apb_o.pslverr = access &&
                         (!mapped || (apb_i.pwrite && apb_i.paddr == REG_EXC_CNT_ADDR));

  // --------------------------------------
  // Window registers
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      region_q.base  <= REGION_BASE_RST;
      region_q.limit <= REGION_LIMIT_RST;
    end else if (wr_en) begin
      if (apb_i.paddr == REG_BASE_ADDR) begin
        region_q.base <= apb_i.pwdata;
      end
      if (apb_i.paddr == REG_LIMIT_ADDR) begin
        region_q.limit <= apb_i.pwdata;
      end
    end
  end

  assign region_o = region_q;

  // Both units may finish an excepted operation in the same cycle
  assign cnt_sum = {1'b0, exc_cnt_q} + {{XLEN{1'b0}}, ld_exc_i} + {{XLEN{1'b0}}, st_exc_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_cnt_q <= '0;
    end else if (cnt_sum[XLEN]) begin
      exc_cnt_q <= '1;
    end else begin
      exc_cnt_q <= cnt_sum[XLEN-1:0];
    end
  end

  a_penable_psel : assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_i.penable |-> apb_i.psel);

endmodule

// ==== rtl/lsu_top.sv ====
// --------------------------------------
// Load/store unit top level
// Results have no back-pressure
// Memory ports hold req until gnt
// --------------------------------------
`timescale 1ns/10ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          lsu_valid_i,
  input  fu_data_t      fu_data_i,
  output logic          lsu_ready_o,
  output load_result_t  load_o,
  output store_result_t store_o,
  output ld_req_t       ld_req_o,
  input  ld_rsp_t       ld_rsp_i,
  output st_req_t       st_req_o,
  input  st_rsp_t       st_rsp_i,
  input  apb_req_t      apb_i,
  output apb_rsp_t      apb_o
);

  lsu_ctrl_t agu_req;
  lsu_ctrl_t head;
  region_t   region;
  logic      ld_valid;
  logic      st_valid;
  logic      ld_pop;
  logic      st_pop;
  logic      ld_busy;
  logic      st_busy;

  lsu_agu i_lsu_agu (
    .fu_data_i (fu_data_i),
    .region_i  (region),
    .req_o     (agu_req)
  );

  lsu_req_buffer i_lsu_req_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (lsu_valid_i & lsu_ready_o),
    .req_i      (agu_req),
    .ready_o    (lsu_ready_o),
    .head_o     (head),
    .ld_valid_o (ld_valid),
    .st_valid_o (st_valid),
    .ld_pop_i   (ld_pop),
    .st_pop_i   (st_pop),
    .ld_busy_i  (ld_busy),
    .st_busy_i  (st_busy)
  );

  lsu_load_unit i_lsu_load_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (ld_valid),
    .req_i    (head),
    .pop_o    (ld_pop),
    .busy_o   (ld_busy),
    .ld_req_o (ld_req_o),
    .ld_rsp_i (ld_rsp_i),
    .load_o   (load_o)
  );

  lsu_store_unit i_lsu_store_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (st_valid),
    .req_i    (head),
    .pop_o    (st_pop),
    .busy_o   (st_busy),
    .st_req_o (st_req_o),
    .st_rsp_i (st_rsp_i),
    .store_o  (store_o)
  );

  lsu_cfg_regs i_lsu_cfg_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .apb_i    (apb_i),
    .apb_o    (apb_o),
    .region_o (region),
    .ld_exc_i (load_o.valid & load_o.ex.valid),
    .st_exc_i (store_o.valid & store_o.ex.valid)
  );

endmodule

// ==== sim/lsu_checker.sv ====
// ----------------------------------------
// Reference model and checks for the LSU
// Shadow memory covers the first 4 KiB
// Results must come back in issue order
// ----------------------------------------
`timescale 1ns/10ps

module lsu_checker
  import lsu_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          lsu_valid_i,
  input  fu_data_t      fu_data_i,
  input  logic          lsu_ready_i,
  input  load_result_t  load_i,
  input  store_result_t store_i,
  input  ld_req_t       ld_req_i,
  input  ld_rsp_t       ld_rsp_i,
  input  st_req_t       st_req_i,
  input  st_rsp_t       st_rsp_i,
  input  apb_req_t      apb_req_i,
  input  apb_rsp_t      apb_rsp_i,
  input  logic          done_i,
  output int            pending_o,
  output int            mismatches_o,
  output int            failures_o
);

  typedef struct packed {
    fu_e                   fu;
    lsu_op_e               op;
    logic [XLEN-1:0]       addr;
    logic [XLEN-1:0]       data;
    logic [TRANS_ID_W-1:0] id;
    logic                  ex;
    exc_cause_e            cause;
  } exp_op_t;

  exp_op_t         exp_q [$];
  logic [XLEN-1:0] shadow [1024];
  region_t         region;
  int              exc_cnt;
  logic            rst_check;
  logic            stall_seen;
  logic            mem_seen;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = {~i[9:0], 6'h2a, i[9:0], 6'h15};
    end
    region       = {REGION_BASE_RST, REGION_LIMIT_RST};
    exc_cnt      = 0;
    rst_check    = 1'b1;
    stall_seen   = 1'b0;
    mem_seen     = 1'b0;
    pending_o    = 0;
    mismatches_o = 0;
    failures_o   = 0;
  end

  task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      mismatches_o++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s at %0t", msg, $time);
    failures_o++;
  endtask

  // ----------------------------------------
  // Reference rules
  // ----------------------------------------
  // Access fault wins over misalignment
  function automatic exp_op_t predict(input fu_data_t d, input region_t win);
    exp_op_t e;
    logic    mis;
    logic    outside;
    e.fu   = d.fu;
    e.op   = d.op;
    e.id   = d.trans_id;
    e.data = d.operand_b;
    e.addr = d.operand_a + d.imm;
    case (d.op)
      LH, LHU, SH: mis = e.addr[0];
      LW, SW:      mis = (e.addr[1:0] != 2'b00);
      default:     mis = 1'b0;
    endcase
    outside = (e.addr < win.base) || (e.addr > win.limit);
    e.ex = mis || outside;
    if (d.fu == FU_STORE) begin
      e.cause = outside ? CAUSE_ST_ACCESS : CAUSE_ST_MISALIGNED;
    end else begin
      e.cause = outside ? CAUSE_LD_ACCESS : CAUSE_LD_MISALIGNED;
    end
    return e;
  endfunction

  function automatic logic [3:0] expected_be(input lsu_op_e op, input logic [1:0] off);
    case (op)
      LB, LBU, SB: return 4'b0001 << off;
      LH, LHU, SH: return 4'b0011 << off;
      default:     return 4'b1111;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] byte_mask(input logic [3:0] be);
    logic [XLEN-1:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  function automatic logic [XLEN-1:0] load_value(input lsu_op_e op, input logic [XLEN-1:0] word,
                                                 input logic [1:0] off);
    logic [XLEN-1:0] w;
    w = word >> {off, 3'b000};
    case (op)
      LB:      return {{24{w[7]}}, w[7:0]};
      LBU:     return {24'h0, w[7:0]};
      LH:      return {{16{w[15]}}, w[15:0]};
      LHU:     return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  // ----------------------------------------
  // Result checks
  // ----------------------------------------
  task automatic check_result(input exp_op_t e, input logic is_load);
    logic [XLEN-1:0] mask;
    if (is_load != (e.fu == FU_LOAD)) begin
      report_failure("result came from the wrong unit for the oldest operation");
      return;
    end
    compare_value(is_load ? "load_o.trans_id" : "store_o.trans_id",
                  32'(is_load ? load_i.trans_id : store_i.trans_id), 32'(e.id));
    compare_value(is_load ? "load_o.ex.valid" : "store_o.ex.valid",
                  32'(is_load ? load_i.ex.valid : store_i.ex.valid), 32'(e.ex));
    if (e.ex) begin
      exc_cnt++;
      compare_value("ex.cause", 32'(is_load ? load_i.ex.cause : store_i.ex.cause), 32'(e.cause));
      compare_value("ex.tval", is_load ? load_i.ex.tval : store_i.ex.tval, e.addr);
    end else if (is_load) begin
      compare_value("load_o.result", load_i.result,
                    load_value(e.op, shadow[e.addr[11:2]], e.addr[1:0]));
    end else begin
      // Shadow memory follows stores in completion order
      mask = byte_mask(expected_be(e.op, e.addr[1:0]));
      shadow[e.addr[11:2]] = (shadow[e.addr[11:2]] & ~mask) |
                             ((e.data << {e.addr[1:0], 3'b000}) & mask);
    end
  endtask

  task automatic check_apb();
    logic            mapped;
    logic [XLEN-1:0] exp_rd;
    mapped = 1'b1;
    exp_rd = '0;
    case (apb_req_i.paddr)
      REG_BASE_ADDR:    exp_rd = region.base;
      REG_LIMIT_ADDR:   exp_rd = region.limit;
      REG_EXC_CNT_ADDR: exp_rd = 32'(exc_cnt);
      default:          mapped = 1'b0;
    endcase
    if (!apb_rsp_i.pready) report_failure("APB access phase without pready");
    compare_value("apb_o.pslverr", 32'(apb_rsp_i.pslverr),
                  32'(!mapped || (apb_req_i.pwrite && apb_req_i.paddr == REG_EXC_CNT_ADDR)));
    if (!apb_req_i.pwrite && mapped) compare_value("apb_o.prdata", apb_rsp_i.prdata, exp_rd);
    if (apb_req_i.pwrite && apb_req_i.paddr == REG_BASE_ADDR) region.base = apb_req_i.pwdata;
    if (apb_req_i.pwrite && apb_req_i.paddr == REG_LIMIT_ADDR) region.limit = apb_req_i.pwdata;
  endtask

  always @(posedge clk_i) begin
    exp_op_t head;
    if (!rst_ni) begin
      rst_check = 1'b1;
    end else begin
      if (rst_check) begin
        rst_check = 1'b0;
        if (!lsu_ready_i) report_failure("lsu_ready_o is low right after reset");
        if (load_i.valid || store_i.valid) report_failure("result valid right after reset");
        if (ld_req_i.req || st_req_i.req) report_failure("memory request right after reset");
      end
      if (ld_req_i.req && st_req_i.req) report_failure("load and store requests at the same time");
      if (ld_req_i.req && ld_rsp_i.gnt) begin
        if (exp_q.size() == 0 || exp_q[0].fu != FU_LOAD || exp_q[0].ex) begin
          report_failure("load request that no pending operation explains");
        end else begin
          head = exp_q[0];
          if (mem_seen) report_failure("second load request for one operation");
          mem_seen = 1'b1;
          compare_value("ld_req_o.addr", ld_req_i.addr, {head.addr[XLEN-1:2], 2'b00});
          compare_value("ld_req_o.be", {28'h0, ld_req_i.be},
                        {28'h0, expected_be(head.op, head.addr[1:0])});
        end
      end
      if (st_req_i.req && st_rsp_i.gnt) begin
        if (exp_q.size() == 0 || exp_q[0].fu != FU_STORE || exp_q[0].ex) begin
          report_failure("store request that no pending operation explains");
        end else begin
          head = exp_q[0];
          if (mem_seen) report_failure("second store request for one operation");
          mem_seen = 1'b1;
          compare_value("st_req_o.addr", st_req_i.addr, {head.addr[XLEN-1:2], 2'b00});
          compare_value("st_req_o.be", {28'h0, st_req_i.be},
                        {28'h0, expected_be(head.op, head.addr[1:0])});
          compare_value("st_req_o.wdata",
                        st_req_i.wdata & byte_mask(expected_be(head.op, head.addr[1:0])),
                        (head.data << {head.addr[1:0], 3'b000}) &
                        byte_mask(expected_be(head.op, head.addr[1:0])));
        end
      end
      if (load_i.valid && store_i.valid) begin
        report_failure("load and store results in the same cycle");
      end else if (load_i.valid || store_i.valid) begin
        if (exp_q.size() == 0) begin
          report_failure("result with no operation outstanding");
        end else begin
          head = exp_q.pop_front();
          check_result(head, load_i.valid);
          if (!head.ex && !mem_seen) begin
            report_failure("result of an operation that made no memory access");
          end
          mem_seen = 1'b0;
        end
      end
      if (apb_req_i.psel && apb_req_i.penable) check_apb();
      if (lsu_valid_i && !lsu_ready_i) stall_seen = 1'b1;
      if (done_i) begin
        if (!stall_seen) report_failure("lsu_ready_o never fell under memory delays");
      end
      // New issue joins after the checks of older operations
      if (lsu_valid_i && lsu_ready_i) exp_q.push_back(predict(fu_data_i, region));
      pending_o = exp_q.size();
    end
  end

endmodule

// ==== sim/tb_lsu.sv ====
// ----------------------------------------
// Testbench for the load/store unit
// Memory model covers the first 4 KiB only
// gnt and rvalid come after 0 to 3 idle cycles
// ----------------------------------------
`timescale 1ns/10ps

module tb_lsu
  import lsu_pkg::*;
();

  localparam int unsigned NUM_OPS    = 400;
  localparam int unsigned CLK_PERIOD = 8;

  logic          clk;
  logic          rst_n;
  logic          lsu_valid;
  logic          lsu_ready;
  logic          done;
  fu_data_t      fu_data;
  load_result_t  load_res;
  store_result_t store_res;
  ld_req_t       ld_req;
  ld_rsp_t       ld_rsp = '0;
  st_req_t       st_req;
  st_rsp_t       st_rsp = '0;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  int            pending;
  int            mismatches;
  int            failures;
  logic [31:0]   mem [1024];
  logic [31:0]   stim_rng;
  logic [31:0]   ld_rng;
  logic [31:0]   st_rng;
  logic [1:0]    ld_wait;
  logic [1:0]    st_wait;
  logic          ld_granted;
  logic [31:0]   ld_addr;

  lsu_top i_lsu_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .lsu_valid_i (lsu_valid),
    .fu_data_i   (fu_data),
    .lsu_ready_o (lsu_ready),
    .load_o      (load_res),
    .store_o     (store_res),
    .ld_req_o    (ld_req),
    .ld_rsp_i    (ld_rsp),
    .st_req_o    (st_req),
    .st_rsp_i    (st_rsp),
    .apb_i       (apb_req),
    .apb_o       (apb_rsp)
  );

  lsu_checker i_lsu_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .lsu_valid_i  (lsu_valid),
    .fu_data_i    (fu_data),
    .lsu_ready_i  (lsu_ready),
    .load_i       (load_res),
    .store_i      (store_res),
    .ld_req_i     (ld_req),
    .ld_rsp_i     (ld_rsp),
    .st_req_i     (st_req),
    .st_rsp_i     (st_rsp),
    .apb_req_i    (apb_req),
    .apb_rsp_i    (apb_rsp),
    .done_i       (done),
    .pending_o    (pending),
    .mismatches_o (mismatches),
    .failures_o   (failures)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  // Load port, rvalid at least one cycle after gnt
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_rsp     <= '0;
      ld_wait    <= 2'd0;
      ld_granted <= 1'b0;
      ld_addr    <= '0;
      ld_rng     <= 32'h5e9c ^ 32'h0f0f_0f0f;
    end else begin
      ld_rsp.gnt    <= 1'b0;
      ld_rsp.rvalid <= 1'b0;
      if (ld_granted) begin
        if (ld_wait == 2'd0) begin
          ld_rsp.rvalid <= 1'b1;
          ld_rsp.rdata  <= mem[ld_addr[11:2]];
          ld_granted    <= 1'b0;
          ld_rng        <= xorshift(ld_rng);
          ld_wait       <= ld_rng[1:0];
        end else begin
          ld_wait <= ld_wait - 2'd1;
        end
      end else if (ld_req.req) begin
        if (ld_wait == 2'd0) begin
          ld_rsp.gnt <= 1'b1;
          ld_addr    <= ld_req.addr;
          ld_granted <= 1'b1;
          ld_rng     <= xorshift(ld_rng);
          ld_wait    <= ld_rng[3:2];
        end else begin
          ld_wait <= ld_wait - 2'd1;
        end
      end
    end
  end

  // Store port, the write lands with gnt
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_rsp  <= '0;
      st_wait <= 2'd0;
      st_rng  <= 32'h5e9c ^ 32'h3c3c_3c3c;
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= {~i[9:0], 6'h2a, i[9:0], 6'h15};
      end
    end else begin
      st_rsp.gnt <= 1'b0;
      if (st_req.req && !st_rsp.gnt) begin
        if (st_wait == 2'd0) begin
          st_rsp.gnt <= 1'b1;
          mem[st_req.addr[11:2]] <= (mem[st_req.addr[11:2]] & ~lane_mask(st_req.be)) |
                                    (st_req.wdata & lane_mask(st_req.be));
          st_rng  <= xorshift(st_rng);
          st_wait <= st_rng[1:0];
        end else begin
          st_wait <= st_wait - 2'd1;
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  // Mostly aligned and inside 0x100..0x2FF, a few misaligned or outside
  task automatic make_op(output fu_data_t op);
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] addr;
    stim_rng = xorshift(stim_rng);
    r = stim_rng;
    stim_rng = xorshift(stim_rng);
    r2 = stim_rng;
    op.op = lsu_op_e'(r[2:0]);
    op.fu = (r[2:0] >= 3'd5) ? FU_STORE : FU_LOAD;
    if (r[7:4] == 4'd0) begin
      addr = r[8] ? 32'h300 + {24'h0, r[16:9]} : {24'h0, r[16:9]};
    end else begin
      addr = 32'h100 + {23'h0, r[15:9], 2'b00};
      case (op.op)
        LB, LBU, SB: addr[1:0] = r[18:17];
        LH, LHU, SH: addr[1] = r[17];
        default: ;
      endcase
      if (r[7:4] inside {4'd1, 4'd2}) begin
        addr[1:0] = {r[18], 1'b1};
      end
    end
    op.imm       = {{20{r2[11]}}, r2[11:0]};
    op.operand_a = addr - op.imm;
    op.trans_id  = r2[14:12];
    stim_rng     = xorshift(stim_rng);
    op.operand_b = stim_rng;
  endtask

  task automatic issue_op(input fu_data_t op);
    lsu_valid <= 1'b1;
    fu_data   <= op;
    @(posedge clk);
    while (!lsu_ready) begin
      @(posedge clk);
    end
    lsu_valid <= 1'b0;
  endtask

  task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req <= '0;
  endtask

  initial begin
    fu_data_t op;
    rst_n     = 1'b0;
    lsu_valid = 1'b0;
    fu_data   = '0;
    apb_req   = '0;
    done      = 1'b0;
    stim_rng  = 32'h5e9c;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Reset window first, then the test region
    apb_access(1'b0, REG_BASE_ADDR, '0);
    apb_access(1'b0, REG_LIMIT_ADDR, '0);
    apb_access(1'b1, REG_BASE_ADDR, 32'h100);
    apb_access(1'b1, REG_LIMIT_ADDR, 32'h2ff);
    apb_access(1'b0, REG_BASE_ADDR, '0);
    apb_access(1'b0, REG_LIMIT_ADDR, '0);
    apb_access(1'b1, REG_EXC_CNT_ADDR, 32'h1234);
    apb_access(1'b1, 32'hc, 32'h1);
    for (int i = 0; i < NUM_OPS; i++) begin
      make_op(op);
      issue_op(op);
      if (stim_rng[7:5] == 3'd0) @(posedge clk);
    end
    @(posedge clk);
    while (pending != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    apb_access(1'b0, REG_EXC_CNT_ADDR, '0);
    done <= 1'b1;
    @(posedge clk);
    done <= 1'b0;
    @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Budget of 20 cycles per operation
  initial begin
    #(NUM_OPS * 20 * CLK_PERIOD);
    $display("Watchdog expired with %0d operations still outstanding", pending);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== build.f ====
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_req_buffer.sv
rtl/lsu_load_unit.sv
rtl/lsu_store_unit.sv
rtl/lsu_cfg_regs.sv
rtl/lsu_top.sv
sim/lsu_checker.sv
sim/tb_lsu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f build.f -o tb_lsu
	./obj_dir/tb_lsu | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
